// ==== bench/lda_props.sv ====
// Bound concurrent assertions on the line-drawing accelerator top-level ports
`timescale 1ns/1ns
`include "lda_params.svh"

module lda_props import lda_pkg::*; (
    input logic   clk,
    input logic   reset,
    input pixel_t o_pixel,
    input logic   o_plot,
    input logic   o_busy,
    input logic   o_done
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Pixels only stream out while a command runs
    plot_while_busy: assert property (@(posedge clk) disable iff (reset)
        o_plot |-> o_busy)
    else begin
        fail_count++;
        $error("o_plot high while o_busy is low");
    end

    coord_in_canvas: assert property (@(posedge clk) disable iff (reset)
        o_plot |-> (o_pixel.x <= `LDA_W_MAX) && (o_pixel.y <= `LDA_H_MAX))
    else begin
        fail_count++;
        $error("Pixel coordinate outside the canvas");
    end

    // Done is a single pulse and the FSM is idle right after it
    done_then_idle: assert property (@(posedge clk) disable iff (reset)
        o_done |=> (!o_done && !o_busy))
    else begin
        fail_count++;
        $error("o_done longer than one cycle or o_busy still high after it");
    end

    no_plot_at_done: assert property (@(posedge clk) disable iff (reset)
        o_done |-> !o_plot)
    else begin
        fail_count++;
        $error("o_plot high in the cycle of o_done");
    end

endmodule

// ==== bench/lda_tb.sv ====
// Testbench for lda_top with reference line model, comparator and timeout
`timescale 1ns/1ns
`include "lda_params.svh"

module lda_tb import lda_pkg::*; ();

    localparam int CLEAR_PIXELS    = (int'(`LDA_W_MAX) + 1) * (int'(`LDA_H_MAX) + 1);
    localparam int MAX_LINE_PIXELS = int'(`LDA_W_MAX) + 1;
    localparam int N_LINES         = 60;
    localparam int TIMEOUT_CYCLES  =
        (CLEAR_PIXELS + 10) + N_LINES * (MAX_LINE_PIXELS + 10) + 2000;

    logic      clk = 1'b0;
    logic      reset;
    logic      i_start;
    cmd_kind_t i_kind;
    line_cmd_t i_cmd;
    pixel_t    o_pixel;
    logic      o_plot;
    logic      o_busy;
    logic      o_done;

    pixel_t exp_q[$];
    pixel_t exp_pix;
    int     mismatch_errors = 0;
    int     other_errors = 0;
    int     done_count = 0;
    int     cycle_count = 0;
    bit     cmd_started = 1'b0;
    integer seed = 38;

    lda_top DUT (
        .clk     (clk),
        .reset   (reset),
        .i_start (i_start),
        .i_kind  (i_kind),
        .i_cmd   (i_cmd),
        .o_pixel (o_pixel),
        .o_plot  (o_plot),
        .o_busy  (o_busy),
        .o_done  (o_done)
    );

    bind lda_top lda_props u_props (
        .clk     (clk),
        .reset   (reset),
        .o_pixel (o_pixel),
        .o_plot  (o_plot),
        .o_busy  (o_busy),
        .o_done  (o_done)
    );

    always #50 clk = ~clk;

    // Expected clear stream in raster order with x fastest
    function automatic void clear_ref();
        int     x;
        int     y;
        pixel_t p;
        for (y = 0; y <= int'(`LDA_H_MAX); y++) begin
            for (x = 0; x <= int'(`LDA_W_MAX); x++) begin
                p.x      = 9'(x);
                p.y      = 8'(y);
                p.colour = '0;
                exp_q.push_back(p);
            end
        end
    endfunction

    // Integer Bresenham that swaps steep lines to x-major and walks the major axis upwards
    function automatic void line_ref(input line_cmd_t c);
        int     a0, a1, b0, b1, t, d_maj, d_min, step, err, a, b;
        bit     steep;
        pixel_t p;
        d_maj = (c.x1 >= c.x0) ? int'(c.x1) - int'(c.x0) : int'(c.x0) - int'(c.x1);
        d_min = (c.y1 >= c.y0) ? int'(c.y1) - int'(c.y0) : int'(c.y0) - int'(c.y1);
        steep = d_min > d_maj;
        a0 = steep ? int'(c.y0) : int'(c.x0);
        a1 = steep ? int'(c.y1) : int'(c.x1);
        b0 = steep ? int'(c.x0) : int'(c.y0);
        b1 = steep ? int'(c.x1) : int'(c.y1);
        if (a0 > a1) begin
            t = a0;
            a0 = a1;
            a1 = t;
            t = b0;
            b0 = b1;
            b1 = t;
        end
        d_maj = a1 - a0;
        d_min = (b1 > b0) ? b1 - b0 : b0 - b1;
        step  = (b1 > b0) ? 1 : ((b1 < b0) ? -1 : 0);
        err   = -(d_maj / 2);
        b     = b0;
        for (a = a0; a <= a1; a++) begin
            p.x      = 9'(steep ? b : a);
            p.y      = 8'(steep ? a : b);
            p.colour = c.colour;
            exp_q.push_back(p);
            if (err + d_min > 0) begin
                b   = b + step;
                err = err + d_min - d_maj;
            end else begin
                err = err + d_min;
            end
        end
    endfunction

    function automatic line_cmd_t make_cmd(input int x0, y0, x1, y1, colour);
        line_cmd_t cmd;
        cmd.x0     = 9'(x0);
        cmd.y0     = 8'(y0);
        cmd.x1     = 9'(x1);
        cmd.y1     = 8'(y1);
        cmd.colour = 3'(colour);
        return cmd;
    endfunction

    // Issue one command, optionally pulse a second start while busy, then wait for done
    task automatic run_cmd(input cmd_kind_t kind, input line_cmd_t cmd, input bit intrude);
        int done_before;
        done_before = done_count;
        if (kind == CMD_CLEAR)
            clear_ref();
        else
            line_ref(cmd);
        @(negedge clk);
        cmd_started = 1'b1;
        i_start = 1'b1;
        i_kind  = kind;
        i_cmd   = cmd;
        @(negedge clk);
        i_start = 1'b0;
        if (intrude) begin
            repeat (20) @(negedge clk);
            i_start = 1'b1;
            i_kind  = CMD_CLEAR;
            i_cmd   = make_cmd(int'(cmd.x1), int'(cmd.y1), int'(cmd.x0), int'(cmd.y0),
                               int'(cmd.colour) + 1);
            @(negedge clk);
            i_start = 1'b0;
        end
        while (done_count == done_before) @(posedge clk);
        repeat (3) @(posedge clk);
        assert (done_count == done_before + 1) else begin
            other_errors++;
            $display("Expected one done pulse but saw %0d at %0t",
                     done_count - done_before, $time);
        end
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("Command ended with %0d expected pixels never drawn", exp_q.size());
            exp_q.delete();
        end
    endtask

    // Comparator on the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (!reset) begin
            if (!cmd_started) begin
                assert (!o_plot && !o_busy && !o_done) else begin
                    other_errors++;
                    $display("Output activity before any start pulse at %0t", $time);
                end
            end
            if (o_plot) begin
                assert (exp_q.size() > 0) else begin
                    other_errors++;
                    $display("Unexpected pixel write at %0t", $time);
                end
                if (exp_q.size() > 0) begin
                    exp_pix = exp_q.pop_front();
                    assert (o_pixel == exp_pix) else begin
                        mismatch_errors++;
                        $display("MISMATCH at %0t: o_pixel got (%0d,%0d,%0d) expected (%0d,%0d,%0d)",
                                 $time, o_pixel.x, o_pixel.y, o_pixel.colour,
                                 exp_pix.x, exp_pix.y, exp_pix.colour);
                    end
                end
            end
            if (o_done)
                done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int n;
        int total_errors;
        reset   = 1'b1;
        i_start = 1'b0;
        i_kind  = CMD_CLEAR;
        i_cmd   = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        // Idle cycles after reset that the comparator checks
        repeat (5) @(negedge clk);

        run_cmd(CMD_CLEAR, '0, 1'b0);

        // Horizontal, vertical, single point and diagonals
        run_cmd(CMD_LINE, make_cmd(10, 20, 200, 20, 1), 1'b0);
        run_cmd(CMD_LINE, make_cmd(50, 5, 50, 200, 2), 1'b0);
        run_cmd(CMD_LINE, make_cmd(7, 9, 7, 9, 3), 1'b0);
        run_cmd(CMD_LINE, make_cmd(0, 0, 210, 210, 4), 1'b0);
        run_cmd(CMD_LINE, make_cmd(300, 0, 100, 200, 5), 1'b0);
        // Steep and reversed endpoints
        run_cmd(CMD_LINE, make_cmd(10, 0, 40, 210, 6), 1'b0);
        run_cmd(CMD_LINE, make_cmd(150, 190, 200, 10, 7), 1'b0);
        run_cmd(CMD_LINE, make_cmd(335, 150, 0, 30, 7), 1'b0);
        run_cmd(CMD_LINE, make_cmd(0, 210, 335, 0, 5), 1'b0);

        // Second start while busy must be dropped
        run_cmd(CMD_LINE, make_cmd(0, 0, 335, 100, 6), 1'b1);

        for (n = 0; n < 50; n++) begin
            run_cmd(CMD_LINE,
                    make_cmd($unsigned($random(seed)) % 336, $unsigned($random(seed)) % 211,
                             $unsigned($random(seed)) % 336, $unsigned($random(seed)) % 211,
                             $unsigned($random(seed)) % 8),
                    1'b0);
        end

        total_errors = mismatch_errors + other_errors + DUT.u_props.fail_count;
        $display("Errors: mismatches=%0d other=%0d assertions=%0d",
                 mismatch_errors, other_errors, DUT.u_props.fail_count);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/lda_control.sv ====
// Command sequencing FSM for the clear and line phases with busy and done
`timescale 1ns/1ns
`include "lda_params.svh"

module lda_control import lda_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_start,
    input  cmd_kind_t i_kind,
    input  logic      i_clear_done,
    input  logic      i_line_done,
    output logic      o_load,
    output logic      o_data_reset,
    output logic      o_clear_canvas,
    output logic      o_start_draw_line,
    output logic      o_draw_line,
    output logic      o_busy,
    output logic      o_done
);

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        CLEAR     = 3'd1,
        LINE_INIT = 3'd2,
        LINE      = 3'd3,
        FINISH    = 3'd4
    } state_t;

    state_t state;
    state_t state_next;
    logic   idle;

    assign idle = (state == IDLE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_start) begin
                    state_next = (i_kind == CMD_CLEAR) ? CLEAR : LINE_INIT;
                end
            end
            CLEAR: begin
                if (i_clear_done) begin
                    state_next = FINISH;
                end
            end
            // Setup values are stable here and the stepper loads them
            LINE_INIT: begin
                state_next = LINE;
            end
            LINE: begin
                if (i_line_done) begin
                    state_next = FINISH;
                end
            end
            FINISH: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Start pulses outside idle are dropped here
    assign o_load            = i_start & idle;
    // Datapath counters and flags restart with every accepted command
    assign o_data_reset      = i_start & idle;
    assign o_clear_canvas    = (state == CLEAR);
    assign o_start_draw_line = (state == LINE_INIT);
    assign o_draw_line       = (state == LINE);
    assign o_busy            = ~idle;
    assign o_done            = (state == FINISH);

endmodule

// ==== hw/lda_datapath.sv ====
// Clear scanner, Bresenham stepper and registered pixel output multiplexer
`timescale 1ns/1ns
`include "lda_params.svh"

module lda_datapath import lda_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  line_setup_t i_setup,
    input  logic        i_data_reset,
    input  logic        i_clear_canvas,
    input  logic        i_start_draw_line,
    input  logic        i_draw_line,
    output logic        o_clear_done,
    output logic        o_line_done,
    output pixel_t      o_pixel,
    output logic        o_plot
);

    // Clear scanner state
    logic [`LDA_XW-1:0] clear_x;
    logic [`LDA_YW-1:0] clear_y;
    logic               clear_step;
    logic               clear_last;

    // Bresenham stepper state
    logic [`LDA_XW-1:0]      loop_maj;
    logic [`LDA_XW-1:0]      loop_min;
    logic signed [`LDA_XW:0] error;
    logic signed [`LDA_XW:0] error_sum;
    logic                    line_step;

    // Output stage
    pixel_t pixel_next;
    logic   plot_next;

    assign clear_step = i_clear_canvas & ~o_clear_done;
    assign clear_last = (clear_x == `LDA_W_MAX) && (clear_y == `LDA_H_MAX);

    // Raster scan with x fastest
    always_ff @(posedge clk) begin
        if (reset || i_data_reset) begin
            clear_x      <= '0;
            clear_y      <= '0;
            o_clear_done <= 1'b0;
        end else if (clear_step) begin
            if (clear_x == `LDA_W_MAX) begin
                clear_x <= '0;
                clear_y <= clear_y + 1'b1;
            end else begin
                clear_x <= clear_x + 1'b1;
            end
            if (clear_last) begin
                o_clear_done <= 1'b1;
            end
        end
    end

    assign line_step = i_draw_line & ~o_line_done;
    assign error_sum = error + i_setup.d_minor;

    always_ff @(posedge clk) begin
        if (i_start_draw_line) begin
            loop_maj <= i_setup.maj_start;
            loop_min <= i_setup.min_start;
            error    <= -(i_setup.d_major >>> 1);
        end else if (line_step) begin
            loop_maj <= loop_maj + 1'b1;
            if (error_sum > 0) begin
                case (i_setup.min_dir)
                    STEP_UP:   loop_min <= loop_min + 1'b1;
                    STEP_DOWN: loop_min <= loop_min - 1'b1;
                    default:   loop_min <= loop_min;
                endcase
                error <= error_sum - i_setup.d_major;
            end else begin
                error <= error_sum;
            end
        end
    end

    // Done once the end point along the major axis has been issued
    always_ff @(posedge clk) begin
        if (reset || i_data_reset || i_start_draw_line) begin
            o_line_done <= 1'b0;
        end else if (line_step && (loop_maj == i_setup.maj_end)) begin
            o_line_done <= 1'b1;
        end
    end

    always_comb begin
        if (i_clear_canvas) begin
            pixel_next.x      = clear_x;
            pixel_next.y      = clear_y;
            pixel_next.colour = '0;
            plot_next         = clear_step;
        end else begin
            // Undo the axis swap of steep lines
            if (i_setup.steep) begin
                pixel_next.x = loop_min;
                pixel_next.y = loop_maj[`LDA_YW-1:0];
            end else begin
                pixel_next.x = loop_maj;
                pixel_next.y = loop_min[`LDA_YW-1:0];
            end
            pixel_next.colour = i_setup.colour;
            plot_next         = line_step;
        end
    end

    always_ff @(posedge clk) begin
        o_pixel <= pixel_next;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_plot <= 1'b0;
        end else begin
            o_plot <= plot_next;
        end
    end

endmodule

// ==== hw/lda_line_setup.sv ====
// Line command normalization into registered Bresenham setup values
`timescale 1ns/1ns
`include "lda_params.svh"

module lda_line_setup import lda_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_load,
    input  line_cmd_t   i_cmd,
    output line_setup_t o_setup
);

    logic [`LDA_XW-1:0] abs_dx;
    logic [`LDA_YW-1:0] abs_dy;
    logic               steep;
    // Endpoints after the optional axis swap with a as the major axis
    logic [`LDA_XW-1:0] a0, a1, b0, b1;
    // Endpoints after ordering along the major axis
    logic [`LDA_XW-1:0] maj0, maj1, min0, min1;
    line_setup_t        setup_next;

    always_comb begin
        abs_dx = (i_cmd.x1 >= i_cmd.x0) ? i_cmd.x1 - i_cmd.x0 : i_cmd.x0 - i_cmd.x1;
        abs_dy = (i_cmd.y1 >= i_cmd.y0) ? i_cmd.y1 - i_cmd.y0 : i_cmd.y0 - i_cmd.y1;
        steep  = {1'b0, abs_dy} > abs_dx;

        if (steep) begin
            a0 = {1'b0, i_cmd.y0};
            a1 = {1'b0, i_cmd.y1};
            b0 = i_cmd.x0;
            b1 = i_cmd.x1;
        end else begin
            a0 = i_cmd.x0;
            a1 = i_cmd.x1;
            b0 = {1'b0, i_cmd.y0};
            b1 = {1'b0, i_cmd.y1};
        end

        // Walk the major axis upwards only
        if (a0 > a1) begin
            maj0 = a1;
            maj1 = a0;
            min0 = b1;
            min1 = b0;
        end else begin
            maj0 = a0;
            maj1 = a1;
            min0 = b0;
            min1 = b1;
        end

        setup_next.steep     = steep;
        setup_next.maj_start = maj0;
        setup_next.maj_end   = maj1;
        setup_next.min_start = min0;
        setup_next.min_end   = min1;
        setup_next.d_major   = {1'b0, maj1 - maj0};
        setup_next.d_minor   = (min1 >= min0) ? {1'b0, min1 - min0} : {1'b0, min0 - min1};
        setup_next.colour    = i_cmd.colour;
        if (min1 > min0)
            setup_next.min_dir = STEP_UP;
        else if (min1 < min0)
            setup_next.min_dir = STEP_DOWN;
        else
            setup_next.min_dir = STEP_NONE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_setup <= '0;
        end else if (i_load) begin
            o_setup <= setup_next;
        end
    end

endmodule

// ==== hw/lda_params.svh ====
// Canvas limits and coordinate, colour widths for the line-drawing accelerator
`ifndef LDA_PARAMS_SVH
`define LDA_PARAMS_SVH

// Largest valid x and y on the 336 x 211 canvas
`define LDA_W_MAX 9'd335
`define LDA_H_MAX 8'd210

// Coordinate widths
`define LDA_XW 9
`define LDA_YW 8

// Colour width of 3 bits per pixel
`define LDA_CW 3

`endif

// ==== hw/lda_pkg.sv ====
// Command, line setup, pixel and command-kind types shared by the accelerator
`include "lda_params.svh"

package lda_pkg;

    // Host command selector
    typedef enum logic {
        CMD_CLEAR = 1'b0,
        CMD_LINE  = 1'b1
    } cmd_kind_t;

    // Direction of the minor-axis step
    typedef enum logic [1:0] {
        STEP_NONE = 2'd0,
        STEP_UP   = 2'd1,
        STEP_DOWN = 2'd2
    } step_dir_t;

    // Line endpoints as given by the host
    typedef struct packed {
        logic [`LDA_XW-1:0] x0;
        logic [`LDA_YW-1:0] y0;
        logic [`LDA_XW-1:0] x1;
        logic [`LDA_YW-1:0] y1;
        logic [`LDA_CW-1:0] colour;
    } line_cmd_t;

    // Normalized x-major line with ascending major coordinate
    typedef struct packed {
        logic                      steep;
        logic [`LDA_XW-1:0]        maj_start;
        logic [`LDA_XW-1:0]        maj_end;
        logic [`LDA_XW-1:0]        min_start;
        logic [`LDA_XW-1:0]        min_end;
        step_dir_t                 min_dir;
        logic signed [`LDA_XW:0]   d_major;
        logic signed [`LDA_XW:0]   d_minor;
        logic [`LDA_CW-1:0]        colour;
    } line_setup_t;

    // One pixel write
    typedef struct packed {
        logic [`LDA_XW-1:0] x;
        logic [`LDA_YW-1:0] y;
        logic [`LDA_CW-1:0] colour;
    } pixel_t;

endpackage

// ==== hw/lda_top.sv ====
// Line-drawing accelerator top level joining setup, control and datapath
`timescale 1ns/1ns
`include "lda_params.svh"

module lda_top import lda_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_start,
    input  cmd_kind_t i_kind,
    input  line_cmd_t i_cmd,
    output pixel_t    o_pixel,
    output logic      o_plot,
    output logic      o_busy,
    output logic      o_done
);

    line_setup_t setup;
    logic        load;
    logic        data_reset;
    logic        clear_canvas;
    logic        start_draw_line;
    logic        draw_line;
    logic        clear_done;
    logic        line_done;

    lda_line_setup u_setup (
        .clk     (clk),
        .reset   (reset),
        .i_load  (load),
        .i_cmd   (i_cmd),
        .o_setup (setup)
    );

    lda_control u_control (
        .clk               (clk),
        .reset             (reset),
        .i_start           (i_start),
        .i_kind            (i_kind),
        .i_clear_done      (clear_done),
        .i_line_done       (line_done),
        .o_load            (load),
        .o_data_reset      (data_reset),
        .o_clear_canvas    (clear_canvas),
        .o_start_draw_line (start_draw_line),
        .o_draw_line       (draw_line),
        .o_busy            (o_busy),
        .o_done            (o_done)
    );

    lda_datapath u_datapath (
        .clk               (clk),
        .reset             (reset),
        .i_setup           (setup),
        .i_data_reset      (data_reset),
        .i_clear_canvas    (clear_canvas),
        .i_start_draw_line (start_draw_line),
        .i_draw_line       (draw_line),
        .o_clear_done      (clear_done),
        .o_line_done       (line_done),
        .o_pixel           (o_pixel),
        .o_plot            (o_plot)
    );

endmodule

// ==== project.f ====
+incdir+hw
hw/lda_pkg.sv
hw/lda_line_setup.sv
hw/lda_control.sv
hw/lda_datapath.sv
hw/lda_top.sv
bench/lda_props.sv
bench/lda_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the line-drawing accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module lda_tb -Mdir obj_dir -o lda_sim -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lda_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1
